/* Bender.yml */
package:
  name: bufctrl

sources:
  - files:
      - hdl/bufctrl_pkg.sv
      - hdl/pytx_acl_buf.sv
      - hdl/pytx_sco_buf.sv
      - hdl/pyrx_acl_buf.sv
      - hdl/pyrx_sco_buf.sv
      - hdl/bufctrl.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/bufctrl_tb.sv

/* dv/bufctrl_model.svh */
`ifndef BUFCTRL_MODEL_SVH
`define BUFCTRL_MODEL_SVH

// words never written since reset read as zero, as in the banks.
logic [word_w-1:0]  m_txa [2][buf_words];
logic [word_w-1:0]  m_txs [2][buf_words];
logic [word_w-1:0]  m_rxa [2][buf_words];
logic [word_w-1:0]  m_rxs [2][buf_words];
logic [pylen_w-1:0] m_rxa_len [2];
logic               m_s1a;
logic               m_txs_ptr;
logic               m_rxs_ptr;
logic               m_wr_ptr;
logic               m_rd_ptr;
logic               m_good_pend;
logic               m_pyp_d;
int                 m_full;
// bit 0 is the transmit LMP flag, bit 1 the receive one.
logic [1:0]         m_lmp_req;
logic [1:0]         m_lmp_slot;

task automatic model_reset();
  for (int b = 0; b < 2; b++)
  begin
    m_rxa_len[b] = '0;
    for (int a = 0; a < buf_words; a++)
    begin
      m_txa[b][a] = '0;
      m_txs[b][a] = '0;
      m_rxa[b][a] = '0;
      m_rxs[b][a] = '0;
    end
  end
  m_s1a       = 1'b0;
  m_txs_ptr   = 1'b0;
  m_rxs_ptr   = 1'b0;
  m_wr_ptr    = 1'b0;
  m_rd_ptr    = 1'b0;
  m_good_pend = 1'b0;
  m_pyp_d     = 1'b0;
  m_full      = 0;
  m_lmp_req   = 2'b00;
  m_lmp_slot  = 2'b00;
endtask

function automatic logic exp_txpybit();
  logic [buf_addr_w-1:0] a;
  logic [word_w-1:0]     w;
  a = pybitcount[bitcnt_w-1 -: buf_addr_w];
  if (!py_datperiod)
    return 1'b0;
  if (m_lmp_slot[0] || !tx_reservedslot)
    w = m_txa[m_s1a][a];
  else
    w = m_txs[!m_txs_ptr][a];
  return w[pybitcount[bitcnt_w-buf_addr_w-1:0]];
endfunction

function automatic logic [word_w-1:0] exp_dout();
  if (rx_acl_rd.cs)
    return m_rxa[m_rd_ptr][rx_acl_rd.addr];
  if (rx_sco_rd.cs)
    return m_rxs[!m_rxs_ptr][rx_sco_rd.addr];
  return '0;
endfunction

function automatic rx_status_t exp_status();
  rx_status_t s;
  s.empty = (m_full == 0);
  s.len   = s.empty ? '0 : m_rxa_len[m_rd_ptr];
  return s;
endfunction

// advances the model over one rising edge with the inputs now driven.
task automatic model_update();
  logic acl_rx;
  logic pk_done;
  logic both_full;
  logic commit;
  logic free_bank;
  acl_rx    = m_lmp_slot[1] || !rx_reservedslot;
  pk_done   = m_pyp_d && !dec_py_period && acl_rx;
  both_full = (m_full == 2);
  commit    = ms_tslot_p && m_good_pend && !both_full;
  free_bank = rx_valid_p && (m_full != 0);
  if (tx_acl_wr.cs && tx_acl_wr.we)
    m_txa[!m_s1a][tx_acl_wr.addr] = tx_acl_wr.din;
  if (tx_sco_wr.cs && tx_sco_wr.we)
    m_txs[m_txs_ptr][tx_sco_wr.addr] = tx_sco_wr.din;
  if (dec_py_period && rx_wr.we && acl_rx && !both_full)
    m_rxa[m_wr_ptr][rx_wr.addr] = rx_wr.din;
  if (dec_py_period && rx_wr.we && !acl_rx)
    m_rxs[m_rxs_ptr][rx_wr.addr] = rx_wr.din;
  if (pk_done && !both_full)
    m_rxa_len[m_wr_ptr] = dec_pylen_byte;
  if (pk_done)
    m_good_pend = dec_hecgood && dec_crcgood;
  else if (ms_tslot_p)
    m_good_pend = 1'b0;
  if (commit)
    m_wr_ptr = !m_wr_ptr;
  if (free_bank)
    m_rd_ptr = !m_rd_ptr;
  m_full = m_full + int'(commit) - int'(free_bank);
  // an ACK moves to new data, a FLOW stop falls back to the previous packet.
  if (py_endp && dec_arqn[ms_lt_addr])
    m_s1a = !m_s1a;
  else if (header_st_p && pk_encode && !dec_flow[ms_lt_addr])
    m_s1a = !m_s1a;
  if (txtsco_p)
    m_txs_ptr = !m_txs_ptr;
  if (rxtsco_p)
    m_rxs_ptr = !m_rxs_ptr;
  if (ms_tslot_p)
    m_lmp_slot = m_lmp_req;
  m_lmp_req = {dec_lmpcmd, regi_lmpcmd_p} | (ms_tslot_p ? 2'b00 : m_lmp_req);
  m_pyp_d   = dec_py_period;
endtask

`endif

/* dv/bufctrl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bufctrl_tb
  import bufctrl_pkg::*;
();

  logic                      clk_6M;
  logic                      rstz;
  bsm_wr_t                   tx_acl_wr;
  bsm_wr_t                   tx_sco_wr;
  bsm_rd_t                   rx_acl_rd;
  bsm_rd_t                   rx_sco_rd;
  logic                      rx_valid_p;
  logic [word_w-1:0]         bsm_dout;
  rx_status_t                rx_acl_status;
  logic [bitcnt_w-1:0]       pybitcount;
  logic                      py_datperiod;
  logic                      dec_py_period;
  lnc_wr_t                   rx_wr;
  logic                      header_st_p;
  logic                      py_endp;
  logic                      pk_encode;
  logic                      dec_hecgood;
  logic                      dec_crcgood;
  logic [pylen_w-1:0]        dec_pylen_byte;
  logic [$clog2(num_lt)-1:0] ms_lt_addr;
  logic [num_lt-1:0]         dec_arqn;
  logic [num_lt-1:0]         dec_flow;
  logic                      ms_tslot_p;
  logic                      regi_lmpcmd_p;
  logic                      dec_lmpcmd;
  logic                      tx_reservedslot;
  logic                      rx_reservedslot;
  logic                      txtsco_p;
  logic                      rxtsco_p;
  logic                      txpybit;

  string cur_test;
  int    test_num;
  int    n_checks;
  int    n_errors;
  int    errors_at_start;
  int    tests_failed;

  `include "bufctrl_model.svh"

  bufctrl dut0 (.*);

  initial
  begin
    clk_6M = 1'b0;
    forever #10 clk_6M = ~clk_6M;
  end

  initial
  begin
    repeat (60000) @(posedge clk_6M);
    $display("timeout: the run did not reach its end within 60000 cycles");
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_bit(string what, logic exp, logic act);
    n_checks++;
    if (act !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %0b actual %0b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_word(string what, logic [word_w-1:0] exp, logic [word_w-1:0] act);
    n_checks++;
    if (act !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_status(string what, rx_status_t exp, rx_status_t act);
    n_checks++;
    if (act !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected empty=%0b len=%0d actual empty=%0b len=%0d",
               cur_test, what, exp.empty, exp.len, act.empty, act.len);
    end
  endtask

  task automatic clear_pulses();
    tx_acl_wr.cs  = 1'b0;
    tx_acl_wr.we  = 1'b0;
    tx_sco_wr.cs  = 1'b0;
    tx_sco_wr.we  = 1'b0;
    rx_acl_rd.cs  = 1'b0;
    rx_sco_rd.cs  = 1'b0;
    rx_wr.we      = 1'b0;
    rx_valid_p    = 1'b0;
    header_st_p   = 1'b0;
    py_endp       = 1'b0;
    ms_tslot_p    = 1'b0;
    regi_lmpcmd_p = 1'b0;
    dec_lmpcmd    = 1'b0;
    txtsco_p      = 1'b0;
    rxtsco_p      = 1'b0;
  endtask

  task automatic drive_idle();
    tx_acl_wr       = '0;
    tx_sco_wr       = '0;
    rx_acl_rd       = '0;
    rx_sco_rd       = '0;
    rx_wr           = '0;
    pybitcount      = '0;
    py_datperiod    = 1'b0;
    dec_py_period   = 1'b0;
    pk_encode       = 1'b0;
    dec_hecgood     = 1'b0;
    dec_crcgood     = 1'b0;
    dec_pylen_byte  = '0;
    ms_lt_addr      = '0;
    dec_arqn        = '0;
    dec_flow        = '1;
    tx_reservedslot = 1'b0;
    rx_reservedslot = 1'b0;
    clear_pulses();
  endtask

  // outputs are compared in the low clock phase, then the model follows the edge.
  task automatic next_cycle();
    #1;
    check_bit("txpybit", exp_txpybit(), txpybit);
    check_word("bsm_dout", exp_dout(), bsm_dout);
    check_status("rx_acl_status", exp_status(), rx_acl_status);
    model_update();
    @(negedge clk_6M);
    clear_pulses();
  endtask

  task automatic write_tx(logic sco, int addr, logic [word_w-1:0] data);
    if (sco)
      tx_sco_wr = '{addr: addr, din: data, we: 1'b1, cs: 1'b1};
    else
      tx_acl_wr = '{addr: addr, din: data, we: 1'b1, cs: 1'b1};
    next_cycle();
  endtask

  task automatic send_tx_period(int nbits, logic reserved);
    tx_reservedslot = reserved;
    py_datperiod    = 1'b1;
    for (int i = 0; i < nbits; i++)
    begin
      pybitcount = i;
      next_cycle();
    end
    py_datperiod = 1'b0;
    pybitcount   = '0;
    next_cycle();
  endtask

  // hec and crc stay valid through the cycle after the payload period.
  task automatic send_rx_period(int nw, logic reserved, logic hec, logic crc,
                                logic [pylen_w-1:0] len);
    rx_reservedslot = reserved;
    dec_hecgood     = hec;
    dec_crcgood     = crc;
    dec_pylen_byte  = len;
    dec_py_period   = 1'b1;
    for (int i = 0; i < nw; i++)
    begin
      rx_wr = '{addr: i, din: $urandom, we: 1'b1};
      next_cycle();
    end
    dec_py_period = 1'b0;
    next_cycle();
    next_cycle();
  endtask

  task automatic read_rx(logic sco, int nw);
    for (int i = 0; i < nw; i++)
    begin
      if (sco)
        rx_sco_rd = '{addr: i, cs: 1'b1};
      else
        rx_acl_rd = '{addr: i, cs: 1'b1};
      next_cycle();
    end
  endtask

  task automatic wait_not_empty(int limit);
    int n;
    n = 0;
    while (rx_acl_status.empty && n < limit)
    begin
      next_cycle();
      n++;
    end
    if (rx_acl_status.empty)
    begin
      n_errors++;
      $display("%s: receive buffer stayed empty for %0d cycles after the slot", cur_test, limit);
    end
  endtask

  task automatic begin_test(string name);
    test_num++;
    cur_test        = name;
    errors_at_start = n_errors;
  endtask

  task automatic end_test();
    if (n_errors == errors_at_start)
    begin
      $display("test %0d %s: passed", test_num, cur_test);
    end
    else
    begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", test_num, cur_test,
               n_errors - errors_at_start);
    end
  endtask

  initial
  begin
    int                 nw;
    logic               hec;
    logic               crc;
    logic [pylen_w-1:0] lens [3];
    void'($urandom(32'h3e5b));
    test_num     = 0;
    n_checks     = 0;
    n_errors     = 0;
    tests_failed = 0;
    rstz         = 1'b0;
    drive_idle();
    model_reset();
    repeat (16) @(negedge clk_6M);
    rstz = 1'b1;

    begin_test("reset_and_acl_tx");
    #1;
    check_bit("txpybit after reset", 1'b0, txpybit);
    check_word("bsm_dout after reset", '0, bsm_dout);
    check_status("status after reset", '{empty: 1'b1, len: '0}, rx_acl_status);
    @(negedge clk_6M);
    nw = 4 + $urandom_range(28);
    for (int i = 0; i < nw; i++)
      write_tx(1'b0, i, $urandom);
    // the ACK brings the freshly written bank to the baseband.
    dec_arqn = '1;
    py_endp  = 1'b1;
    next_cycle();
    dec_arqn = '0;
    send_tx_period(32 * nw - $urandom_range(31), 1'b0);
    end_test();

    begin_test("s1a_switching");
    for (int k = 0; k < 24; k++)
    begin
      for (int i = 0; i < 3; i++)
        write_tx(1'b0, $urandom_range(7), $urandom);
      ms_lt_addr = $urandom_range(num_lt - 1);
      dec_arqn   = $urandom;
      dec_flow   = $urandom;
      pk_encode  = $urandom_range(1);
      if ($urandom_range(1))
        py_endp = 1'b1;
      else
        header_st_p = 1'b1;
      next_cycle();
      send_tx_period(64 + $urandom_range(191), 1'b0);
    end
    end_test();

    begin_test("sco_tx");
    for (int i = 0; i < 4; i++)
      write_tx(1'b1, i, $urandom);
    txtsco_p = 1'b1;
    next_cycle();
    send_tx_period(128, 1'b1);
    regi_lmpcmd_p = 1'b1;
    next_cycle();
    ms_tslot_p = 1'b1;
    next_cycle();
    send_tx_period(128, 1'b1);
    ms_tslot_p = 1'b1;
    next_cycle();
    for (int i = 0; i < 4; i++)
      write_tx(1'b1, i, $urandom);
    txtsco_p = 1'b1;
    next_cycle();
    send_tx_period(128, 1'b1);
    end_test();

    begin_test("acl_rx_commit");
    for (int k = 0; k < 12; k++)
    begin
      nw  = 1 + $urandom_range(15);
      hec = ($urandom_range(3) != 0);
      crc = ($urandom_range(3) != 0);
      send_rx_period(nw, 1'b0, hec, crc, 4 * nw - $urandom_range(3));
      ms_tslot_p = 1'b1;
      next_cycle();
      if (hec && crc)
      begin
        wait_not_empty(4);
        read_rx(1'b0, nw);
        rx_valid_p = 1'b1;
      end
      next_cycle();
    end
    end_test();

    begin_test("acl_rx_backpressure");
    for (int k = 0; k < 3; k++)
    begin
      lens[k] = 4 * (k + 2);
      send_rx_period(k + 2, 1'b0, 1'b1, 1'b1, lens[k]);
      ms_tslot_p = 1'b1;
      next_cycle();
    end
    check_status("after third packet", '{empty: 1'b0, len: lens[0]}, rx_acl_status);
    read_rx(1'b0, 2);
    rx_valid_p = 1'b1;
    next_cycle();
    check_status("after first release", '{empty: 1'b0, len: lens[1]}, rx_acl_status);
    read_rx(1'b0, 3);
    rx_valid_p = 1'b1;
    next_cycle();
    check_status("after second release", '{empty: 1'b1, len: '0}, rx_acl_status);
    end_test();

    begin_test("sco_rx");
    nw = 8;
    send_rx_period(nw, 1'b1, 1'b1, 1'b1, 4 * nw);
    rxtsco_p = 1'b1;
    next_cycle();
    read_rx(1'b1, nw);
    dec_lmpcmd = 1'b1;
    next_cycle();
    ms_tslot_p = 1'b1;
    next_cycle();
    send_rx_period(nw, 1'b1, 1'b1, 1'b1, 4 * nw);
    ms_tslot_p = 1'b1;
    next_cycle();
    wait_not_empty(4);
    check_status("after LMP slot", '{empty: 1'b0, len: 4 * nw}, rx_acl_status);
    read_rx(1'b0, nw);
    rx_valid_p = 1'b1;
    next_cycle();
    end_test();

    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             test_num, test_num - tests_failed, tests_failed, n_checks, n_errors);
    if (n_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/bufctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module bufctrl
  import bufctrl_pkg::*;
(
  input  logic                       clk_6M,
  input  logic                       rstz,
  input  bsm_wr_t                    tx_acl_wr,
  input  bsm_wr_t                    tx_sco_wr,
  input  bsm_rd_t                    rx_acl_rd,
  input  bsm_rd_t                    rx_sco_rd,
  input  logic                       rx_valid_p,
  output logic [word_w-1:0]          bsm_dout,
  output rx_status_t                 rx_acl_status,
  input  logic [bitcnt_w-1:0]        pybitcount,
  input  logic                       py_datperiod,
  input  logic                       dec_py_period,
  input  lnc_wr_t                    rx_wr,
  input  logic                       header_st_p,
  input  logic                       py_endp,
  input  logic                       pk_encode,
  input  logic                       dec_hecgood,
  input  logic                       dec_crcgood,
  input  logic [pylen_w-1:0]         dec_pylen_byte,
  input  logic [$clog2(num_lt)-1:0]  ms_lt_addr,
  input  logic [num_lt-1:0]          dec_arqn,
  input  logic [num_lt-1:0]          dec_flow,
  input  logic                       ms_tslot_p,
  input  logic                       regi_lmpcmd_p,
  input  logic                       dec_lmpcmd,
  input  logic                       tx_reservedslot,
  input  logic                       rx_reservedslot,
  input  logic                       txtsco_p,
  input  logic                       rxtsco_p,
  output logic                       txpybit
);

  localparam int bit_idx_w = bitcnt_w - buf_addr_w;

  logic [1:0]            lmp_req;
  logic [1:0]            lmp_slot;
  logic                  s1a;
  logic                  dec_py_period_d;
  logic [buf_addr_w-1:0] tx_addr;
  logic [bit_idx_w-1:0]  tx_bit_idx;
  logic                  tx_acl_sel;
  logic                  tx_sco_sel;
  logic [word_w-1:0]     tx_acl_dout;
  logic [word_w-1:0]     tx_sco_dout;
  logic [word_w-1:0]     tx_word;
  logic                  rx_acl_slot;
  logic                  rx_acl_cs;
  logic                  rx_sco_cs;
  logic                  pk_done;
  logic [word_w-1:0]     rx_acl_dout;
  logic [word_w-1:0]     rx_sco_dout;

  // bit 0 is the transmit LMP slot, bit 1 the receive one.
  // an LMP command only ever claims the single slot after its request.
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      lmp_req  <= 2'b00;
      lmp_slot <= 2'b00;
    end
    else
    begin
      if (ms_tslot_p)
        lmp_slot <= lmp_req;
      lmp_req <= {dec_lmpcmd, regi_lmpcmd_p} | (lmp_req & {2{~ms_tslot_p}});
    end
  end

  // an ACK moves on to new data; a FLOW stop falls back to the previous packet.
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      s1a <= 1'b0;
    else if (py_endp && dec_arqn[ms_lt_addr])
      s1a <= ~s1a;
    else if (header_st_p && pk_encode && !dec_flow[ms_lt_addr])
      s1a <= ~s1a;
  end

  assign tx_addr    = pybitcount[bitcnt_w-1 -: buf_addr_w];
  assign tx_bit_idx = pybitcount[bit_idx_w-1:0];
  assign tx_acl_sel = py_datperiod & (lmp_slot[0] | ~tx_reservedslot);
  assign tx_sco_sel = py_datperiod & ~lmp_slot[0] & tx_reservedslot;

  assign tx_word = tx_acl_sel ? tx_acl_dout : (tx_sco_sel ? tx_sco_dout : '0);
  assign txpybit = tx_word[tx_bit_idx];

  // pk_done marks the cycle after an ACL payload period ends.
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      dec_py_period_d <= 1'b0;
    else
      dec_py_period_d <= dec_py_period;
  end

  assign rx_acl_slot = lmp_slot[1] | ~rx_reservedslot;
  assign rx_acl_cs   = dec_py_period & rx_acl_slot;
  assign rx_sco_cs   = dec_py_period & ~rx_acl_slot;
  assign pk_done     = dec_py_period_d & ~dec_py_period & rx_acl_slot;

  pytx_acl_buf pytx_acl_buf0 (
    .clk_6M   (clk_6M),
    .rstz     (rstz),
    .bsm      (tx_acl_wr),
    .lnc_addr (tx_addr),
    .bank_sel (s1a),
    .lnc_dout (tx_acl_dout)
  );

  pytx_sco_buf pytx_sco_buf0 (
    .clk_6M   (clk_6M),
    .rstz     (rstz),
    .tsco_p   (txtsco_p),
    .bsm      (tx_sco_wr),
    .lnc_addr (tx_addr),
    .lnc_dout (tx_sco_dout)
  );

  pyrx_acl_buf pyrx_acl_buf0 (
    .clk_6M     (clk_6M),
    .rstz       (rstz),
    .pk_done    (pk_done),
    .hecgood    (dec_hecgood),
    .crcgood    (dec_crcgood),
    .ms_tslot_p (ms_tslot_p),
    .pylen_byte (dec_pylen_byte),
    .valid_p    (rx_valid_p),
    .bsm        (rx_acl_rd),
    .lnc        (rx_wr),
    .lnc_cs     (rx_acl_cs),
    .bsm_dout   (rx_acl_dout),
    .status     (rx_acl_status)
  );

  pyrx_sco_buf pyrx_sco_buf0 (
    .clk_6M   (clk_6M),
    .rstz     (rstz),
    .tsco_p   (rxtsco_p),
    .bsm      (rx_sco_rd),
    .lnc      (rx_wr),
    .lnc_cs   (rx_sco_cs),
    .bsm_dout (rx_sco_dout)
  );

  always_comb
  begin
    if (rx_acl_rd.cs)
      bsm_dout = rx_acl_dout;
    else if (rx_sco_rd.cs)
      bsm_dout = rx_sco_dout;
    else
      bsm_dout = '0;
  end

endmodule

`default_nettype wire

/* hdl/bufctrl_pkg.sv */
`default_nettype none

package bufctrl_pkg;

  // each bank holds one maximum-length payload as 32-bit words.
  localparam int buf_words  = 256;
  localparam int buf_addr_w = 8;
  localparam int word_w     = 32;

  // the ARQN and FLOW vectors carry one bit per logical transport.
  localparam int num_lt     = 8;

  localparam int pylen_w    = 10;

  // upper bits select the word, lower bits select the bit inside it.
  localparam int bitcnt_w   = 13;

  // host write port of a transmit buffer.
  typedef struct packed {
    logic [buf_addr_w-1:0] addr;
    logic [word_w-1:0]     din;
    logic                  we;
    logic                  cs;
  } bsm_wr_t;

  // host read port of a receive buffer.
  typedef struct packed {
    logic [buf_addr_w-1:0] addr;
    logic                  cs;
  } bsm_rd_t;

  // baseband write port of a receive buffer.
  typedef struct packed {
    logic [buf_addr_w-1:0] addr;
    logic [word_w-1:0]     din;
    logic                  we;
  } lnc_wr_t;

  // len is the payload length of the bank the host is reading.
  typedef struct packed {
    logic               empty;
    logic [pylen_w-1:0] len;
  } rx_status_t;

endpackage

`default_nettype wire

/* hdl/pyrx_acl_buf.sv */
`timescale 1ns/10ps
`default_nettype none

module pyrx_acl_buf
  import bufctrl_pkg::*;
(
  input  logic               clk_6M,
  input  logic               rstz,
  input  logic               pk_done,
  input  logic               hecgood,
  input  logic               crcgood,
  input  logic               ms_tslot_p,
  input  logic [pylen_w-1:0] pylen_byte,
  input  logic               valid_p,
  input  bsm_rd_t            bsm,
  input  lnc_wr_t            lnc,
  input  logic               lnc_cs,
  output logic [word_w-1:0]  bsm_dout,
  output rx_status_t         status
);

  logic [word_w-1:0]          mem [2][buf_words];
  logic [1:0][buf_words-1:0]  vld;
  logic [pylen_w-1:0]         len_q [2];
  logic                       wr_ptr;
  logic                       rd_ptr;
  logic [1:0]                 full_cnt;
  logic                       good_pend;
  logic                       both_full;
  logic                       lnc_wen;
  logic                       commit;
  logic                       free_bank;

  assign both_full = (full_cnt == 2'd2);
  assign lnc_wen   = lnc_cs & lnc.we & ~both_full;

  // a good packet is handed to the host at the next slot boundary.
  assign commit    = ms_tslot_p & good_pend & ~both_full;
  assign free_bank = valid_p & (full_cnt != 2'd0);

  always_ff @(posedge clk_6M)
  begin
    if (lnc_wen)
    begin
      mem[wr_ptr][lnc.addr] <= lnc.din;
    end
    if (pk_done && !both_full)
    begin
      len_q[wr_ptr] <= pylen_byte;
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      good_pend <= 1'b0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      full_cnt  <= 2'd0;
      vld       <= '0;
    end
    else
    begin
      // hec and crc status are sampled with the end-of-payload flag.
      if (pk_done)
        good_pend <= hecgood & crcgood;
      else if (ms_tslot_p)
        good_pend <= 1'b0;
      if (commit)
        wr_ptr <= ~wr_ptr;
      if (free_bank)
        rd_ptr <= ~rd_ptr;
      if (commit && !free_bank)
        full_cnt <= full_cnt + 2'd1;
      else if (free_bank && !commit)
        full_cnt <= full_cnt - 2'd1;
      if (lnc_wen)
        vld[wr_ptr][lnc.addr] <= 1'b1;
    end
  end

  assign bsm_dout = vld[rd_ptr][bsm.addr] ? mem[rd_ptr][bsm.addr] : '0;

  always_comb
  begin
    status.empty = (full_cnt == 2'd0);
    status.len   = status.empty ? '0 : len_q[rd_ptr];
  end

endmodule

`default_nettype wire

/* hdl/pyrx_sco_buf.sv */
`timescale 1ns/10ps
`default_nettype none

module pyrx_sco_buf
  import bufctrl_pkg::*;
(
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              tsco_p,
  input  bsm_rd_t           bsm,
  input  lnc_wr_t           lnc,
  input  logic              lnc_cs,
  output logic [word_w-1:0] bsm_dout
);

  logic [word_w-1:0]          mem [2][buf_words];
  logic [1:0][buf_words-1:0]  vld;
  logic                       ptr;
  logic                       lnc_wen;

  assign lnc_wen = lnc_cs & lnc.we;

  // the baseband fills bank ptr while the host drains the other one.
  always_ff @(posedge clk_6M)
  begin
    if (lnc_wen)
    begin
      mem[ptr][lnc.addr] <= lnc.din;
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      ptr <= 1'b0;
      vld <= '0;
    end
    else
    begin
      if (tsco_p)
      begin
        ptr <= ~ptr;
      end
      if (lnc_wen)
      begin
        vld[ptr][lnc.addr] <= 1'b1;
      end
    end
  end

  assign bsm_dout = vld[~ptr][bsm.addr] ? mem[~ptr][bsm.addr] : '0;

endmodule

`default_nettype wire

/* hdl/pytx_acl_buf.sv */
`timescale 1ns/10ps
`default_nettype none

module pytx_acl_buf
  import bufctrl_pkg::*;
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  bsm_wr_t               bsm,
  input  logic [buf_addr_w-1:0] lnc_addr,
  input  logic                  bank_sel,
  output logic [word_w-1:0]     lnc_dout
);

  logic [word_w-1:0]          mem [2][buf_words];
  logic [1:0][buf_words-1:0]  vld;
  logic                       wr_bank;
  logic                       bsm_wen;

  // the host always fills the bank the baseband is not sending from.
  assign wr_bank = ~bank_sel;
  assign bsm_wen = bsm.cs & bsm.we;

  always_ff @(posedge clk_6M)
  begin
    if (bsm_wen)
    begin
      mem[wr_bank][bsm.addr] <= bsm.din;
    end
  end

  // words never written since reset read as zero.
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      vld <= '0;
    end
    else if (bsm_wen)
    begin
      vld[wr_bank][bsm.addr] <= 1'b1;
    end
  end

  always_comb
  begin
    if (vld[bank_sel][lnc_addr])
    begin
      lnc_dout = mem[bank_sel][lnc_addr];
    end
    else
    begin
      lnc_dout = '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/pytx_sco_buf.sv */
`timescale 1ns/10ps
`default_nettype none

module pytx_sco_buf
  import bufctrl_pkg::*;
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  tsco_p,
  input  bsm_wr_t               bsm,
  input  logic [buf_addr_w-1:0] lnc_addr,
  output logic [word_w-1:0]     lnc_dout
);

  logic [word_w-1:0]          mem [2][buf_words];
  logic [1:0][buf_words-1:0]  vld;
  logic                       ptr;
  logic                       bsm_wen;

  assign bsm_wen = bsm.cs & bsm.we;

  // the host fills bank ptr, the baseband sends the other one.
  always_ff @(posedge clk_6M)
  begin
    if (bsm_wen)
    begin
      mem[ptr][bsm.addr] <= bsm.din;
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      ptr <= 1'b0;
      vld <= '0;
    end
    else
    begin
      if (tsco_p)
      begin
        ptr <= ~ptr;
      end
      if (bsm_wen)
      begin
        vld[ptr][bsm.addr] <= 1'b1;
      end
    end
  end

  assign lnc_dout = vld[~ptr][lnc_addr] ? mem[~ptr][lnc_addr] : '0;

endmodule

`default_nettype wire

/* project.f */
+incdir+dv
hdl/bufctrl_pkg.sv
hdl/pytx_acl_buf.sv
hdl/pytx_sco_buf.sv
hdl/pyrx_acl_buf.sv
hdl/pyrx_sco_buf.sv
hdl/bufctrl.sv
dv/bufctrl_tb.sv
